// ==== design/memStage_macros.svh ====
`ifndef MEMSTAGE_MACROS_SVH
`define MEMSTAGE_MACROS_SVH

// Data and address word width
`define DATA_W 16

// RAM decodes the low address bits only
// 10 bits give 1024 words
`define MEM_ADDR_BITS 10

// Stack pointer after reset
// Points at the top word of the RAM
`define SP_RESET 16'h03FF

// Lowest allowed stack pointer before overflow
`define LIMIT_RESET 16'h0300

// Config register word offsets
`define CFG_SPINIT 0
`define CFG_LIMIT 1
`define CFG_STATUS 2
`define CFG_SP 3

`endif

// ==== design/memStagePkg.sv ====
`include "memStage_macros.svh"

package memStagePkg;

    // Widths with a meaning
    typedef logic [`DATA_W-1:0] dataWord;
    typedef logic [`DATA_W-1:0] addrWord;
    typedef logic [2:0] regAddr;
    // Interrupt push slot
    // 0 Rsrc, 1 PC high, 2 PC low, 3 flags
    typedef logic [1:0] intSlot;

    // Execute/memory pipeline record
    typedef struct packed {
        logic        valid;
        dataWord     aluResult;
        dataWord     rsrcValue;
        dataWord     rdstValue;
        regAddr      rdstAddr;
        logic        memRead;
        logic        memWrite;
        logic        writeBack;
        logic        push;
        logic        pop;
        logic        intActive;
        intSlot      slot;
        logic [31:0] pc;
        dataWord     flags;
    } exMemRec;

    // Memory/write-back pipeline record
    typedef struct packed {
        logic    valid;
        dataWord aluResult;
        regAddr  rdstAddr;
        logic    memRead;
        logic    writeBack;
        dataWord memData;
    } memWbRec;

    // Wishbone classic master to slave
    typedef struct packed {
        logic    cyc;
        logic    stb;
        logic    we;
        addrWord adr;
        dataWord datW;
    } wbReq;

    // Wishbone classic slave to master
    typedef struct packed {
        logic    ack;
        dataWord datR;
    } wbRsp;

    // Bus master FSM of the memory stage
    typedef enum logic [1:0] {
        Idle,
        Access,
        Done
    } stageState;

endpackage

// ==== design/dataMemory.sv ====
`timescale 1ns/100ps
`include "memStage_macros.svh"

module dataMemory
    import memStagePkg::*;
(
    input  logic clk,
    input  logic reset,
    input  wbReq memReq,
    output wbRsp memRsp
);

    localparam int memWords = 1 << `MEM_ADDR_BITS;

    dataWord                  mem [0:memWords-1];
    logic [`MEM_ADDR_BITS-1:0] index;
    logic                     start;
    logic                     ackReg;
    dataWord                  rdData;

    // Upper address bits ignored so addresses wrap
    assign index = memReq.adr[`MEM_ADDR_BITS-1:0];

    // First cycle of a request
    // Blocked while ack is out so one request gives one ack
    assign start = memReq.cyc & memReq.stb & ~ackReg;

    // RAM contents start at zero
    initial begin
        for (int i = 0; i < memWords; i++) begin
            mem[i] = '0;
        end
    end

    // Write port
    always_ff @(posedge clk) begin
        if (start && memReq.we) begin
            mem[index] <= memReq.datW;
        end
    end

    // Read word registered with the ack
    always_ff @(posedge clk) begin
        if (start) begin
            rdData <= mem[index];
        end
    end

    // Ack one cycle after the request is seen
    always_ff @(posedge clk) begin
        if (reset) begin
            ackReg <= 1'b0;
        end else begin
            ackReg <= start;
        end
    end

    assign memRsp = '{ack: ackReg, datR: rdData};

endmodule

// ==== design/stackPointer.sv ====
`timescale 1ns/100ps
`include "memStage_macros.svh"

module stackPointer
    import memStagePkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    pushDone,
    input  logic    popDone,
    input  logic    reload,
    input  addrWord spInit,
    input  addrWord spLimit,
    output addrWord spValue,
    output logic    overflow
);

    addrWord sp;
    addrWord spDec;
    addrWord spInc;

    // Stack grows downward
    // Push writes at SP then decrements
    assign spDec = sp - 1'b1;
    // Pop increments then reads at the new SP
    assign spInc = sp + 1'b1;

    // Reload from config wins over a stack update in the same cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            sp <= `SP_RESET;
        end else if (reload) begin
            sp <= spInit;
        end else if (pushDone) begin
            sp <= spDec;
        end else if (popDone) begin
            sp <= spInc;
        end
    end

    assign spValue = sp;

    // Overflow when pushing at the limit
    // Compared against SP before the push
    // The push itself still completes
    assign overflow = pushDone & (sp == spLimit);

endmodule

// ==== design/stackConfigRegs.sv ====
`timescale 1ns/100ps
`include "memStage_macros.svh"

module stackConfigRegs
    import memStagePkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  wbReq    cfgReq,
    output wbRsp    cfgRsp,
    input  addrWord spValue,
    input  logic    overflow,
    output addrWord spInit,
    output addrWord spLimit,
    output logic    reload
);

    logic    start;
    logic    wrEn;
    logic    ackReg;
    logic    ovfFlag;
    dataWord rdData;
    dataWord rdMux;

    // First cycle of an access
    assign start = cfgReq.cyc & cfgReq.stb & ~ackReg;
    assign wrEn = start & cfgReq.we;

    // Read decode
    // Unmapped offsets return zero
    always_comb begin
        case (cfgReq.adr)
            `CFG_SPINIT: rdMux = spInit;
            `CFG_LIMIT:  rdMux = spLimit;
            `CFG_STATUS: rdMux = {{(`DATA_W-1){1'b0}}, ovfFlag};
            `CFG_SP:     rdMux = spValue;
            default:     rdMux = '0;
        endcase
    end

    // Registers, ack and reload pulse
    always_ff @(posedge clk) begin
        if (reset) begin
            spInit  <= `SP_RESET;
            spLimit <= `LIMIT_RESET;
            ackReg  <= 1'b0;
            reload  <= 1'b0;
        end else begin
            ackReg <= start;
            // Reload follows the init write by one cycle
            // spInit already holds the new value then
            reload <= wrEn && (cfgReq.adr == `CFG_SPINIT);
            if (wrEn && (cfgReq.adr == `CFG_SPINIT)) begin
                spInit <= cfgReq.datW;
            end
            if (wrEn && (cfgReq.adr == `CFG_LIMIT)) begin
                spLimit <= cfgReq.datW;
            end
        end
    end

    // Sticky overflow status, write one to clear
    // A new overflow beats a clear in the same cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            ovfFlag <= 1'b0;
        end else if (overflow) begin
            ovfFlag <= 1'b1;
        end else if (wrEn && (cfgReq.adr == `CFG_STATUS) && cfgReq.datW[0]) begin
            ovfFlag <= 1'b0;
        end
    end

    // Read data captured with the ack
    always_ff @(posedge clk) begin
        if (start) begin
            rdData <= rdMux;
        end
    end

    assign cfgRsp = '{ack: ackReg, datR: rdData};

endmodule

// ==== design/memoryStage.sv ====
`timescale 1ns/100ps

module memoryStage
    import memStagePkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  exMemRec exIn,
    output logic    stall,
    input  addrWord spValue,
    output logic    pushDone,
    output logic    popDone,
    output wbReq    memReq,
    input  wbRsp    memRsp,
    output memWbRec wbOut
);

    stageState state;
    stageState nextState;
    exMemRec   held;
    logic      accept;
    logic      memOp;
    logic      stackOp;
    logic      finish;
    logic      heldLoad;
    addrWord   reqAddr;
    dataWord   slotData;
    dataWord   reqData;

    // Any record that touches the data memory
    assign memOp = exIn.memRead | exIn.memWrite | exIn.push | exIn.pop;
    assign stackOp = exIn.push | exIn.pop;

    // Busy for the whole bus access, ack cycle included
    assign stall = (state == Access);
    assign accept = exIn.valid & ~stall;
    assign finish = (state == Access) & memRsp.ack;

    // Interrupt push data per slot
    always_comb begin
        case (exIn.slot)
            2'd0:    slotData = exIn.rsrcValue;
            2'd1:    slotData = exIn.pc[31:16];
            2'd2:    slotData = exIn.pc[15:0];
            default: slotData = exIn.flags;
        endcase
    end

    assign reqData = exIn.intActive ? slotData : exIn.rsrcValue;

    // Address select
    // Stack operations take priority over plain loads and stores
    always_comb begin
        if (exIn.push) begin
            reqAddr = spValue;
        end else if (exIn.pop) begin
            reqAddr = spValue + 1'b1;
        end else if (exIn.memRead) begin
            reqAddr = exIn.rsrcValue;
        end else begin
            reqAddr = exIn.rdstValue;
        end
    end

    // Done is the single cycle after ack
    // It takes new records like Idle
    always_comb begin
        case (state)
            Idle, Done: begin
                if (accept && memOp) begin
                    nextState = Access;
                end else begin
                    nextState = Idle;
                end
            end
            Access: begin
                nextState = memRsp.ack ? Done : Access;
            end
            default: nextState = Idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= Idle;
        end else begin
            state <= nextState;
        end
    end

    // Bus request registered at acceptance
    // Held steady until the ack edge
    always_ff @(posedge clk) begin
        if (reset) begin
            memReq <= '0;
        end else if (accept && memOp) begin
            memReq.cyc  <= 1'b1;
            memReq.stb  <= 1'b1;
            memReq.we   <= stackOp ? exIn.push : exIn.memWrite;
            memReq.adr  <= reqAddr;
            memReq.datW <= reqData;
        end else if (finish) begin
            memReq.cyc <= 1'b0;
            memReq.stb <= 1'b0;
            memReq.we  <= 1'b0;
        end
    end

    // Record kept for completion of the access
    always_ff @(posedge clk) begin
        if (accept) begin
            held <= exIn;
        end
    end

    // Pop also loads a register
    assign heldLoad = held.memRead | held.pop;

    // SP update on the ack edge
    assign pushDone = finish & held.push;
    assign popDone = finish & held.pop & ~held.push;

    // Memory/write-back register
    // Accept and finish never coincide since stall covers Access
    always_ff @(posedge clk) begin
        if (reset) begin
            wbOut <= '0;
        end else if (finish) begin
            wbOut.valid     <= 1'b1;
            wbOut.aluResult <= held.aluResult;
            wbOut.rdstAddr  <= held.rdstAddr;
            wbOut.memRead   <= heldLoad;
            wbOut.writeBack <= held.writeBack;
            wbOut.memData   <= heldLoad ? memRsp.datR : '0;
        end else if (accept && !memOp) begin
            // Pass-through record
            wbOut.valid     <= 1'b1;
            wbOut.aluResult <= exIn.aluResult;
            wbOut.rdstAddr  <= exIn.rdstAddr;
            wbOut.memRead   <= 1'b0;
            wbOut.writeBack <= exIn.writeBack;
            wbOut.memData   <= '0;
        end else begin
            wbOut.valid <= 1'b0;
        end
    end

endmodule

// ==== design/memSubsystemTop.sv ====
`timescale 1ns/100ps

module memSubsystemTop
    import memStagePkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  exMemRec exIn,
    output logic    stall,
    output memWbRec wbOut,
    input  wbReq    cfgReq,
    output wbRsp    cfgRsp
);

    // Data memory bus
    wbReq    memReq;
    wbRsp    memRsp;
    // Stack pointer control
    logic    pushDone;
    logic    popDone;
    logic    reload;
    logic    overflow;
    addrWord spValue;
    addrWord spInit;
    addrWord spLimit;

    memoryStage u_stage (
        .clk      (clk),
        .reset    (reset),
        .exIn     (exIn),
        .stall    (stall),
        .spValue  (spValue),
        .pushDone (pushDone),
        .popDone  (popDone),
        .memReq   (memReq),
        .memRsp   (memRsp),
        .wbOut    (wbOut)
    );

    stackPointer u_sp (
        .clk      (clk),
        .reset    (reset),
        .pushDone (pushDone),
        .popDone  (popDone),
        .reload   (reload),
        .spInit   (spInit),
        .spLimit  (spLimit),
        .spValue  (spValue),
        .overflow (overflow)
    );

    // Config slave steering the stack pointer
    stackConfigRegs u_cfg (
        .clk      (clk),
        .reset    (reset),
        .cfgReq   (cfgReq),
        .cfgRsp   (cfgRsp),
        .spValue  (spValue),
        .overflow (overflow),
        .spInit   (spInit),
        .spLimit  (spLimit),
        .reload   (reload)
    );

    dataMemory u_mem (
        .clk    (clk),
        .reset  (reset),
        .memReq (memReq),
        .memRsp (memRsp)
    );

endmodule

// ==== verification/memStage_assertions.sv ====
`timescale 1ns/100ps

module memStageAssertions
    import memStagePkg::*;
(
    input logic    clk,
    input logic    reset,
    input exMemRec exIn,
    input logic    stall,
    input wbReq    memReq,
    input wbRsp    memRsp,
    input memWbRec wbOut
);

    // Request frozen until the slave acks
    reqStable: assert property (@(posedge clk) disable iff (reset)
        (memReq.cyc && memReq.stb && !memRsp.ack) |=> $stable(memReq))
        else $error("memReq changed before ack");

    // Stage free again once the record has left
    stallAfterOut: assert property (@(posedge clk) disable iff (reset)
        (wbOut.valid && !exIn.valid) |=> !stall)
        else $error("stall still high after wbOut.valid with nothing pending");

    // Back-to-back valid only when a new record was taken
    validOnce: assert property (@(posedge clk) disable iff (reset)
        (wbOut.valid && !(exIn.valid && !stall)) |=> !wbOut.valid)
        else $error("wbOut.valid held for more than one cycle");

    cycWithStb: assert property (@(posedge clk) disable iff (reset)
        memReq.cyc |-> memReq.stb)
        else $error("memReq.cyc high without memReq.stb");

endmodule

bind memoryStage memStageAssertions u_checks (
    .clk    (clk),
    .reset  (reset),
    .exIn   (exIn),
    .stall  (stall),
    .memReq (memReq),
    .memRsp (memRsp),
    .wbOut  (wbOut)
);

// ==== verification/memStageTb.sv ====
`timescale 1ns/100ps
`include "memStage_macros.svh"

module memStageTb
    import memStagePkg::*;
();

    localparam int clkPeriod = 100;
    localparam int numRandom = 200;
    localparam int lifoDepth = 8;
    // Random ops, stack runs and config traffic
    localparam int totalOps = numRandom + 2 * lifoDepth + 24;
    localparam int watchdogCycles = totalOps * 10 + 100;
    localparam int memWords = 1 << `MEM_ADDR_BITS;
    // Codes 2 and 3 load, 4 and 5 store, 6 push, 7 pop, others pass through
    localparam int kindPush = 6;
    localparam int kindPop = 7;

    logic    clk;
    logic    reset;
    exMemRec exIn;
    logic    stall;
    memWbRec wbOut;
    wbReq    cfgReq;
    wbRsp    cfgRsp;

    // Reference model state
    dataWord     modelMem [0:memWords-1];
    addrWord     modelSp;
    addrWord     modelLimit;
    logic        modelStatus;
    memWbRec     expectQ [$];
    int          acceptCount;
    int          validCount;
    logic [31:0] lfsrState;

    memSubsystemTop u_dut (
        .clk    (clk),
        .reset  (reset),
        .exIn   (exIn),
        .stall  (stall),
        .wbOut  (wbOut),
        .cfgReq (cfgReq),
        .cfgRsp (cfgRsp)
    );

    always #(clkPeriod / 2) clk = ~clk;

    // Fibonacci LFSR with taps 32 22 2 1
    // One step per bit
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], fb};
            v = {v[30:0], lfsrState[0]};
        end
        return v;
    endfunction

    // Words 0 to 15 with random upper bits so addresses wrap
    function automatic addrWord windowAddr();
        addrWord a;
        a = '0;
        a[15:10] = 6'(randBits(6));
        a[3:0] = 4'(randBits(4));
        return a;
    endfunction

    // Interrupt push data
    function automatic dataWord slotValue(input exMemRec r);
        case (r.slot)
            2'd0:    return r.rsrcValue;
            2'd1:    return r.pc[31:16];
            2'd2:    return r.pc[15:0];
            default: return r.flags;
        endcase
    endfunction

    function automatic exMemRec randomRecord(input int kind);
        exMemRec r;
        r = '0;
        r.aluResult = dataWord'(randBits(16));
        r.rsrcValue = dataWord'(randBits(16));
        r.rdstValue = dataWord'(randBits(16));
        r.rdstAddr = regAddr'(randBits(3));
        r.writeBack = 1'(randBits(1));
        r.intActive = 1'(randBits(1));
        r.slot = intSlot'(randBits(2));
        r.pc = randBits(32);
        r.flags = dataWord'(randBits(16));
        case (kind)
            2, 3: begin
                r.memRead = 1'b1;
                r.rsrcValue = windowAddr();
            end
            4, 5: begin
                r.memWrite = 1'b1;
                r.rdstValue = windowAddr();
            end
            kindPush: r.push = 1'b1;
            kindPop:  r.pop = 1'b1;
            default:  r.intActive = 1'b0;
        endcase
        return r;
    endfunction

    task automatic stopOnError(input string line);
        $display("%s", line);
        $display("STATUS: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic checkRec(input string name, input memWbRec exp, input memWbRec act);
        if (exp !== act) begin
            stopOnError($sformatf("Fail at %0t: %s expected %h actual %h",
                $time, name, exp, act));
        end
    endtask

    task automatic checkData(input string name, input dataWord exp, input dataWord act);
        if (exp !== act) begin
            stopOnError($sformatf("Fail at %0t: %s expected %h actual %h",
                $time, name, exp, act));
        end
    endtask

    task automatic checkAddr(input string name, input addrWord exp, input addrWord act);
        if (exp !== act) begin
            stopOnError($sformatf("Fail at %0t: %s expected %h actual %h",
                $time, name, exp, act));
        end
    endtask

    // Reference model of one accepted record
    task automatic predict(input exMemRec r);
        memWbRec e;
        dataWord wrData;
        wrData = r.intActive ? slotValue(r) : r.rsrcValue;
        e = '0;
        e.valid = 1'b1;
        e.aluResult = r.aluResult;
        e.rdstAddr = r.rdstAddr;
        e.writeBack = r.writeBack;
        if (r.push) begin
            // Overflow looks at SP before the push
            if (modelSp == modelLimit) begin
                modelStatus = 1'b1;
            end
            modelMem[modelSp[`MEM_ADDR_BITS-1:0]] = wrData;
            modelSp = modelSp - 16'd1;
        end else if (r.pop) begin
            modelSp = modelSp + 16'd1;
            e.memRead = 1'b1;
            e.memData = modelMem[modelSp[`MEM_ADDR_BITS-1:0]];
        end else if (r.memRead) begin
            e.memRead = 1'b1;
            e.memData = modelMem[r.rsrcValue[`MEM_ADDR_BITS-1:0]];
        end else if (r.memWrite) begin
            modelMem[r.rdstValue[`MEM_ADDR_BITS-1:0]] = wrData;
        end
        expectQ.push_back(e);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Present a record and hold it while stalled
    task automatic sendRecord(input exMemRec r);
        r.valid = 1'b1;
        exIn = r;
        while (stall) begin
            idle(1);
        end
        // Taken on the coming edge
        predict(r);
        acceptCount++;
        idle(1);
        exIn.valid = 1'b0;
    endtask

    task automatic drain();
        int cycles;
        cycles = 0;
        while (expectQ.size() != 0 && cycles < 20) begin
            idle(1);
            cycles++;
        end
        if (expectQ.size() != 0) begin
            stopOnError("pending records never appeared on wbOut");
        end
    endtask

    // One config bus access
    // Request held through the ack cycle
    task automatic cfgAccess(input logic we, input addrWord adr, input dataWord wdata,
                             output dataWord rdata);
        int cycles;
        cfgReq = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, datW: wdata};
        cycles = 0;
        do begin
            idle(1);
            cycles++;
        end while (!cfgRsp.ack && cycles < 8);
        if (!cfgRsp.ack) begin
            stopOnError("config slave never acknowledged the access");
        end
        rdata = cfgRsp.datR;
        idle(1);
        cfgReq = '0;
    endtask

    task automatic cfgWrite(input addrWord adr, input dataWord data);
        dataWord ignored;
        cfgAccess(1'b1, adr, data, ignored);
    endtask

    task automatic cfgReadCheck(input addrWord adr, input dataWord exp, input string name);
        dataWord got;
        cfgAccess(1'b0, adr, '0, got);
        checkData(name, exp, got);
    endtask

    task automatic checkSp();
        dataWord got;
        cfgAccess(1'b0, `CFG_SP, '0, got);
        checkAddr("cfgRsp.datR SP readback", modelSp, addrWord'(got));
    endtask

    // Output monitor sampled mid cycle
    always @(negedge clk) begin : monitor
        memWbRec exp;
        if (!reset && wbOut.valid) begin
            validCount++;
            if (expectQ.size() == 0) begin
                stopOnError("wbOut.valid rose with no accepted record pending");
            end else begin
                exp = expectQ.pop_front();
                checkRec("wbOut", exp, wbOut);
            end
        end
    end

    initial begin
        #(watchdogCycles * clkPeriod);
        stopOnError("simulation timed out before the tests finished");
    end

    initial begin
        exMemRec r;
        dataWord newInit;
        clk = 1'b0;
        reset = 1'b1;
        exIn = '0;
        cfgReq = '0;
        lfsrState = 32'd82988;
        modelSp = `SP_RESET;
        modelLimit = `LIMIT_RESET;
        modelStatus = 1'b0;
        acceptCount = 0;
        validCount = 0;
        for (int i = 0; i < memWords; i++) begin
            modelMem[i] = '0;
        end
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        // Random mix with gaps
        for (int i = 0; i < numRandom; i++) begin
            sendRecord(randomRecord(int'(randBits(3))));
            if (randBits(1)) begin
                idle(int'(randBits(2)));
            end
        end
        drain();
        checkSp();

        // Interrupt pushes over all slots
        // Popped back in LIFO order
        for (int i = 0; i < lifoDepth; i++) begin
            r = randomRecord(kindPush);
            r.intActive = 1'b1;
            r.slot = intSlot'(i);
            sendRecord(r);
        end
        for (int i = 0; i < lifoDepth; i++) begin
            sendRecord(randomRecord(kindPop));
        end
        drain();
        checkSp();

        // Reload and readback
        newInit = 16'h0380 + dataWord'(randBits(6));
        cfgWrite(`CFG_SPINIT, newInit);
        modelSp = newInit;
        modelLimit = newInit - 16'h0040;
        cfgWrite(`CFG_LIMIT, modelLimit);
        cfgReadCheck(`CFG_SPINIT, newInit, "cfgRsp.datR SP init");
        cfgReadCheck(`CFG_LIMIT, modelLimit, "cfgRsp.datR limit");
        cfgReadCheck(16'd5, 16'd0, "cfgRsp.datR unmapped");
        checkSp();

        // Push exactly at the limit
        cfgWrite(`CFG_LIMIT, modelSp);
        modelLimit = modelSp;
        cfgReadCheck(`CFG_STATUS, dataWord'(modelStatus), "cfgRsp.datR status");
        sendRecord(randomRecord(kindPush));
        drain();
        cfgReadCheck(`CFG_STATUS, 16'd1, "cfgRsp.datR status after overflow");
        cfgWrite(`CFG_STATUS, 16'h0001);
        modelStatus = 1'b0;
        cfgReadCheck(`CFG_STATUS, 16'd0, "cfgRsp.datR status after clear");
        sendRecord(randomRecord(kindPop));
        drain();
        checkSp();

        idle(2);
        if (acceptCount == validCount && expectQ.size() == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            stopOnError($sformatf("accepted %0d records but counted %0d wbOut pulses",
                acceptCount, validCount));
        end
    end

endmodule

// ==== flist.f ====
+incdir+design
design/memStagePkg.sv
design/dataMemory.sv
design/stackPointer.sv
design/stackConfigRegs.sv
design/memoryStage.sv
design/memSubsystemTop.sv
verification/memStage_assertions.sv
verification/memStageTb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the memory stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f flist.f --top-module memStageTb \
    -Mdir obj_dir -o memStageSim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator compile failed with status $status"
    exit $status
fi

./obj_dir/memStageSim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

echo "Simulation completed"
exit 0
